/* src/ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int haddr_width = 32; // full ahb address
  localparam int hdata_width = 32; // hwdata / hrdata

  // --------------------------------------------------
  // transfer type, htrans encoding
  // --------------------------------------------------
  typedef enum logic [1:0] {
    trans_idle   = 2'b00, // no transfer
    trans_busy   = 2'b01, // master inserts idle beat in a burst
    trans_nonseq = 2'b10, // single or first beat
    trans_seq    = 2'b11  // remaining beats of a burst
  } htrans_e;

  // response, ahb-lite has one bit
  localparam logic hresp_okay  = 1'b0;
  localparam logic hresp_error = 1'b1;

endpackage

`default_nettype wire

/* src/sfr_pkg.sv */
`default_nettype none

package sfr_pkg;

  // --------------------------------------------------
  // register word
  // --------------------------------------------------
  localparam int sfr_width = 16;              // every register is this wide
  typedef logic [sfr_width-1:0] sfr_word_t;

  // --------------------------------------------------
  // register map, byte offsets
  // --------------------------------------------------
  localparam int unsigned cr_base   = 'h000;  // control reg i at cr_base + 4i
  localparam int unsigned cr_max    = 8;      // room reserved for control regs
  localparam int unsigned sr_offset = 'h020;  // status, read only
  localparam int unsigned fr_offset = 'h024;  // sticky flags, w1c
  localparam int unsigned ar_offset = 'h028;  // action, reads as 0

  localparam sfr_word_t cr_reset_value = 16'h00ff;
  localparam sfr_word_t ar_key         = 16'h0032; // magic word that fires the action

  // which register an address selects
  typedef enum logic [2:0] {
    kind_ctrl,
    kind_status,
    kind_flag,
    kind_action,
    kind_none
  } sfr_kind_e;

  // shared address decode for both register stages
  // the control window covers cr_max slots; each stage checks its own count
  function automatic sfr_kind_e sfr_decode(input logic [31:0] addr);
    sfr_kind_e kind;
    kind = kind_none;
    if (addr[1:0] != 2'b00)
      kind = kind_none;                       // only word aligned offsets map
    else if ((addr >= cr_base) && (addr < cr_base + 4 * cr_max))
      kind = kind_ctrl;
    else if (addr == sr_offset)
      kind = kind_status;
    else if (addr == fr_offset)
      kind = kind_flag;
    else if (addr == ar_offset)
      kind = kind_action;
    return kind;
  endfunction

endpackage

`default_nettype wire

/* src/sfr_access_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one decoded register access, valid during the ahb data phase
interface sfr_access_if #(
  parameter int addr_width = 12
);

  import ahb_pkg::*;

  logic [addr_width-1:0]  addr;     // captured address phase address
  logic                   read_en;  // one cycle, data phase of a read
  logic                   write_en; // one cycle, data phase of a write
  logic [hdata_width-1:0] wdata;    // live hwdata

  // --------------------------------------------------
  // capture stage drives, register stages listen
  // --------------------------------------------------
  modport source (
    output addr,
    output read_en,
    output write_en,
    output wdata
  );

  modport sink (
    input addr,
    input read_en,
    input write_en,
    input wdata
  );

endinterface

`default_nettype wire

/* src/ahb_addr_phase.sv */
`timescale 1ns/1ps
`default_nettype none

// ahb address phase capture
// turns a pipelined ahb transfer into a register strobe aligned with its data
module ahb_addr_phase #(
  parameter int addr_width = 12
) (
  input  logic                                hclk,
  input  logic                                hresetn,
  input  logic                                hsel,
  input  logic [addr_width-1:0]               haddr,
  input  ahb_pkg::htrans_e                    htrans,
  input  logic                                hwrite,
  input  logic                                hready,
  input  logic [ahb_pkg::hdata_width-1:0]     hwdata,
  sfr_access_if.source                        acc
);

  import ahb_pkg::*;

  logic                  trans_req;  // accepted address phase this cycle
  logic                  rd_req;
  logic                  wr_req;
  logic [addr_width-1:0] addr_q;
  logic                  read_en_q;
  logic                  write_en_q;

  // --------------------------------------------------
  // address phase qualification
  // --------------------------------------------------
  // idle and busy beats never start an access
  assign trans_req = hsel & hready &
                     ((htrans == trans_nonseq) | (htrans == trans_seq));
  assign rd_req    = trans_req & ~hwrite;
  assign wr_req    = trans_req &  hwrite;

  // address held into the data phase
  always_ff @(posedge hclk)
  begin
    if (trans_req)
      addr_q <= haddr;
  end

  // --------------------------------------------------
  // read / write strobes
  // --------------------------------------------------
  // hready high ends any data phase in flight; the strobes then take
  // whatever the new address phase asks for, which is 0 if none follows
  always_ff @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
    begin
      read_en_q  <= 1'b0;
      write_en_q <= 1'b0;
    end
    else if (hready)
    begin
      read_en_q  <= rd_req;
      write_en_q <= wr_req;
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------
  assign acc.addr     = addr_q;
  assign acc.read_en  = read_en_q;
  assign acc.write_en = write_en_q;
  assign acc.wdata    = hwdata;     // write data arrives in the data phase itself

endmodule

`default_nettype wire

/* src/sfr_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// control register array plus the keyed action pulse
module sfr_ctrl_regs #(
  parameter int addr_width = 12,
  parameter int cr_count   = 4     // 1 to 8
) (
  input  logic                                 hclk,
  input  logic                                 hresetn,
  sfr_access_if.sink                           acc,
  input  logic                                 sfr_lock,
  output sfr_pkg::sfr_word_t [cr_count-1:0]    cr,
  output logic                                 cr_action,
  output sfr_pkg::sfr_word_t                   ctrl_rdata
);

  import ahb_pkg::*;
  import sfr_pkg::*;

  sfr_kind_e kind;      // register selected by the data phase address
  logic [2:0] cr_idx;   // control register slot
  logic       cr_hit;   // slot exists in this build
  logic       wr_ok;    // write allowed this cycle
  logic       cr_wr;
  logic       ar_fire;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  assign kind   = sfr_decode(32'(acc.addr));
  assign cr_idx = 3'((acc.addr - addr_width'(cr_base)) >> 2);
  assign cr_hit = (kind == kind_ctrl) && (32'(cr_idx) < cr_count); // upper slots unmapped

  assign wr_ok   = acc.write_en & ~sfr_lock;      // lock kills every write
  assign cr_wr   = wr_ok & cr_hit;
  // full word compare, stray upper bits do not fire
  assign ar_fire = wr_ok && (kind == kind_action) &&
                   (acc.wdata == hdata_width'(ar_key));

  // --------------------------------------------------
  // control registers
  // --------------------------------------------------
  always_ff @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
      cr <= {cr_count{cr_reset_value}};
    else
    begin
      for (int i = 0; i < cr_count; i++)
      begin
        if (cr_wr && (cr_idx == 3'(i)))
          cr[i] <= acc.wdata[sfr_width-1:0]; // full word writes only, low half kept
      end
    end
  end

  // action pulse, one cycle after the write data phase
  always_ff @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
      cr_action <= 1'b0;
    else
      cr_action <= ar_fire;   // drops again next cycle unless re-written
  end

  // --------------------------------------------------
  // read contribution
  // --------------------------------------------------
  // zero unless a read selects one of our slots, so the next stage can just OR
  always_comb
  begin
    ctrl_rdata = '0;
    if (acc.read_en && cr_hit)
    begin
      for (int i = 0; i < cr_count; i++)
      begin
        if (cr_idx == 3'(i))
          ctrl_rdata = cr[i];
      end
    end
  end

endmodule

`default_nettype wire

/* src/sfr_flag_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// sticky flags, status readback and the final hrdata merge
module sfr_flag_regs #(
  parameter int addr_width = 12
) (
  input  logic                                hclk,
  input  logic                                hresetn,
  sfr_access_if.sink                          acc,
  input  logic                                sfr_lock,
  input  sfr_pkg::sfr_word_t                  status,
  input  sfr_pkg::sfr_word_t                  flag_set,
  output sfr_pkg::sfr_word_t                  flags,
  input  sfr_pkg::sfr_word_t                  ctrl_rdata,
  output logic [ahb_pkg::hdata_width-1:0]     hrdata
);

  import ahb_pkg::*;
  import sfr_pkg::*;

  sfr_kind_e             kind;
  logic [addr_width-1:0] acc_addr;    // local copy, decoded below
  logic                  fr_wr;       // w1c write to the flag word
  sfr_word_t             clr_mask;    // bits software clears this cycle
  sfr_word_t             own_rdata;   // status or flags, zero otherwise

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  assign acc_addr = acc.addr;
  assign kind     = sfr_decode(32'(acc_addr));

  assign fr_wr    = acc.write_en & ~sfr_lock & (kind == kind_flag);
  assign clr_mask = fr_wr ? acc.wdata[sfr_width-1:0] : '0;

  // --------------------------------------------------
  // sticky flags
  // --------------------------------------------------
  // hw set beats sw clear when both hit the same bit
  always_ff @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
      flags <= '0;
    else
      flags <= (flags & ~clr_mask) | flag_set;
  end

  // --------------------------------------------------
  // read path
  // --------------------------------------------------
  always_comb
  begin
    own_rdata = '0;
    if (acc.read_en)
    begin
      case (kind)
        kind_status: own_rdata = status;  // live input, sampled in data phase
        kind_flag:   own_rdata = flags;
        default:     own_rdata = '0;      // action and unmapped read 0
      endcase
    end
  end

  // control stage is already zero when not selected
  assign hrdata = hdata_width'(own_rdata | ctrl_rdata);

endmodule

`default_nettype wire

/* src/ahb_sfr_top.sv */
`timescale 1ns/1ps
`default_nettype none

// ahb-lite register slave
// address capture -> control regs -> flag/status regs with read merge
module ahb_sfr_top #(
  parameter int addr_width = 12,   // decoded low address bits
  parameter int cr_count   = 4     // control registers, 1 to 8
) (
  input  logic                                 hclk,
  input  logic                                 hresetn,
  // ahb-lite slave side
  input  logic                                 hsel,
  input  logic [ahb_pkg::haddr_width-1:0]      haddr,
  input  logic [1:0]                           htrans,
  input  logic                                 hwrite,
  input  logic                                 hready,
  input  logic [ahb_pkg::hdata_width-1:0]      hwdata,
  output logic [ahb_pkg::hdata_width-1:0]      hrdata,
  output logic                                 hreadyout,
  output logic                                 hresp,
  // register side
  input  logic                                 sfr_lock,
  input  sfr_pkg::sfr_word_t                   status,
  input  sfr_pkg::sfr_word_t                   flag_set,
  output sfr_pkg::sfr_word_t                   flags,
  output sfr_pkg::sfr_word_t [cr_count-1:0]    cr,
  output logic                                 cr_action
);

  import ahb_pkg::*;
  import sfr_pkg::*;

  htrans_e   htrans_t;     // typed view of htrans
  sfr_word_t ctrl_rdata;   // control stage read data into the merge

  // --------------------------------------------------
  // bus glue
  // --------------------------------------------------
  assign htrans_t  = htrans_e'(htrans);
  assign hreadyout = 1'b1;          // never stalls the bus
  assign hresp     = hresp_okay;    // never errors

  sfr_access_if #(
    .addr_width (addr_width)
  ) u_acc ();

  // --------------------------------------------------
  // stage 1: address phase capture
  // --------------------------------------------------
  ahb_addr_phase #(
    .addr_width (addr_width)
  ) u_addr_phase (
    .hclk    (hclk),
    .hresetn (hresetn),
    .hsel    (hsel),
    .haddr   (haddr[addr_width-1:0]),  // upper bits already decoded into hsel
    .htrans  (htrans_t),
    .hwrite  (hwrite),
    .hready  (hready),
    .hwdata  (hwdata),
    .acc     (u_acc.source)
  );

  // --------------------------------------------------
  // stage 2: control and action registers
  // --------------------------------------------------
  sfr_ctrl_regs #(
    .addr_width (addr_width),
    .cr_count   (cr_count)
  ) u_ctrl_regs (
    .hclk       (hclk),
    .hresetn    (hresetn),
    .acc        (u_acc.sink),
    .sfr_lock   (sfr_lock),
    .cr         (cr),
    .cr_action  (cr_action),
    .ctrl_rdata (ctrl_rdata)
  );

  // --------------------------------------------------
  // stage 3: flags, status, read merge
  // --------------------------------------------------
  sfr_flag_regs #(
    .addr_width (addr_width)
  ) u_flag_regs (
    .hclk       (hclk),
    .hresetn    (hresetn),
    .acc        (u_acc.sink),
    .sfr_lock   (sfr_lock),
    .status     (status),
    .flag_set   (flag_set),
    .flags      (flags),
    .ctrl_rdata (ctrl_rdata),
    .hrdata     (hrdata)
  );

endmodule

`default_nettype wire

/* tb/ahb_sfr_bus_tasks.svh */
`ifndef ahb_sfr_bus_tasks_svh
`define ahb_sfr_bus_tasks_svh

// --------------------------------------------------
// cycle driver
// --------------------------------------------------
// every bus task steps time through here, so side inputs move on the rising edge only
task automatic next_cycle();
  @(posedge hclk);
  status   <= 16'($random(seed)); // fresh status word each cycle
  flag_set <= set_next;           // armed set bits last one cycle
  sfr_lock <= lock_level;
  set_next = '0;
endtask

// one address phase; the data of the previous write goes out in the same cycle
task automatic address_phase(input logic [11:0] addr, input logic write,
                             input logic [31:0] data, input logic [1:0] trans);
  next_cycle();
  hsel   <= 1'b1;
  haddr  <= {20'h0, addr};
  htrans <= trans;
  hwrite <= write;
  hwdata <= wdata_next;
  wdata_next = write ? data : 32'($random(seed)); // reads carry junk on hwdata
endtask

// no new transfer, ends a data phase in flight
task automatic bus_idle();
  next_cycle();
  hsel   <= 1'b0;
  htrans <= 2'b00;
  hwrite <= 1'b0;
  hwdata <= wdata_next;
  wdata_next = 32'($random(seed));
endtask

// --------------------------------------------------
// transfers
// --------------------------------------------------
task automatic write_word(input logic [11:0] addr, input logic [31:0] data);
  address_phase(addr, 1'b1, data, 2'b10);
  bus_idle();
endtask

task automatic read_word(input logic [11:0] addr);
  address_phase(addr, 1'b0, '0, 2'b10);
  bus_idle();
endtask

// read issued in the write's data phase, sees the new value
task automatic write_then_read(input logic [11:0] addr, input logic [31:0] data);
  address_phase(addr, 1'b1, data, 2'b10);
  address_phase(addr, 1'b0, '0, 2'b11);
  bus_idle();
endtask

// busy beat with hsel high, must not write
task automatic busy_beat(input logic [11:0] addr, input logic [31:0] data);
  next_cycle();
  hsel   <= 1'b1;
  haddr  <= {20'h0, addr};
  htrans <= 2'b01;
  hwrite <= 1'b1;
  hwdata <= wdata_next;
  wdata_next = data;
  bus_idle();
endtask

// --------------------------------------------------
// flag events
// --------------------------------------------------
task automatic pulse_flags(input sfr_word_t bits);
  set_next = bits;
  bus_idle();
endtask

// w1c write whose data phase meets a hardware set
task automatic clear_flags_during_set(input sfr_word_t clr, input sfr_word_t bits);
  address_phase(fr_addr, 1'b1, {16'h0, clr}, 2'b10);
  set_next = bits;                 // lands in the data phase cycle
  bus_idle();
endtask

`endif

/* tb/ahb_sfr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_sfr_tb;

  import sfr_pkg::*;

  localparam int cr_count       = 4;
  localparam int timeout_cycles = 600; // ~200 transfers at 2 cycles plus margin
  localparam logic [11:0] sr_addr = 12'(sr_offset);
  localparam logic [11:0] fr_addr = 12'(fr_offset);
  localparam logic [11:0] ar_addr = 12'(ar_offset);

  logic                        hclk;
  logic                        hresetn;
  logic                        hsel;
  logic [31:0]                 haddr;
  logic [1:0]                  htrans;
  logic                        hwrite;
  logic                        hready;
  logic [31:0]                 hwdata;
  logic [31:0]                 hrdata;
  logic                        hreadyout;
  logic                        hresp;
  logic                        sfr_lock;
  sfr_word_t                   status;
  sfr_word_t                   flag_set;
  sfr_word_t                   flags;
  sfr_word_t [cr_count-1:0]    cr;
  logic                        cr_action;

  integer      seed = 32'h9052_9ed0;
  sfr_word_t   set_next;        // flag bits for the next cycle
  logic        lock_level;
  logic [31:0] wdata_next;      // hwdata of the pending data phase
  int          cycle_count;

  // reference model state
  logic [11:0]              m_addr;
  logic                     m_rd;
  logic                     m_wr;
  sfr_word_t [cr_count-1:0] m_cr;
  sfr_word_t                m_flags;
  logic                     m_action;
  int                       wr_slot;
  logic                     m_wr_ok;
  logic [31:0]              exp_rdata;

  // --------------------------------------------------
  // failure reporting
  // --------------------------------------------------
  task automatic stop_run_failed();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what);
    $display("[FAIL] %0.1f ns: %s", $realtime, what);
    stop_run_failed();
  endtask

  `include "ahb_sfr_bus_tasks.svh"

  // control slot for a word address, -1 if none
  function automatic int ctrl_slot(input logic [11:0] a);
    for (int i = 0; i < cr_count; i++)
      if (a == 12'(cr_base + 4 * i))
        return i;
    return -1;
  endfunction

  function automatic logic [31:0] expected_rdata(input logic [11:0] a, input sfr_word_t st,
                                                 input sfr_word_t fl,
                                                 input sfr_word_t [cr_count-1:0] regs);
    logic [31:0] v;
    v = '0;                        // unmapped and action read 0
    if (ctrl_slot(a) >= 0)
      v = {16'h0, regs[ctrl_slot(a)]};
    else if (a == sr_addr)
      v = {16'h0, st};
    else if (a == fr_addr)
      v = {16'h0, fl};
    return v;
  endfunction

  initial
  begin
    hclk = 1'b0;
    forever #2 hclk = ~hclk;  // 4 ns period
  end

  ahb_sfr_top #(
    .addr_width (12),
    .cr_count   (cr_count)
  ) u_dut (
    .hclk      (hclk),
    .hresetn   (hresetn),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hready    (hready),
    .hwdata    (hwdata),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .sfr_lock  (sfr_lock),
    .status    (status),
    .flag_set  (flag_set),
    .flags     (flags),
    .cr        (cr),
    .cr_action (cr_action)
  );

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  assign wr_slot   = ctrl_slot(m_addr);
  assign m_wr_ok   = m_wr & ~sfr_lock;   // lock seen in the data phase
  assign exp_rdata = expected_rdata(m_addr, status, m_flags, m_cr);

  always @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
    begin
      m_addr   <= '0;
      m_rd     <= 1'b0;
      m_wr     <= 1'b0;
      m_cr     <= {cr_count{cr_reset_value}};
      m_flags  <= '0;
      m_action <= 1'b0;
    end
    else
    begin
      if (m_wr_ok && (wr_slot >= 0))
        m_cr[wr_slot] <= hwdata[15:0];
      // set wins over a clear of the same bit
      m_flags  <= (m_flags & ~((m_wr_ok && (m_addr == fr_addr)) ? hwdata[15:0] : 16'h0))
                  | flag_set;
      m_action <= m_wr_ok && (m_addr == ar_addr) && (hwdata == 32'(ar_key));
      if (hready)
      begin
        m_rd <= hsel && ((htrans == 2'b10) || (htrans == 2'b11)) && !hwrite;
        m_wr <= hsel && ((htrans == 2'b10) || (htrans == 2'b11)) && hwrite;
        if (hsel && ((htrans == 2'b10) || (htrans == 2'b11)))
          m_addr <= haddr[11:0];
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_reset: assert property (@(posedge hclk) !hresetn |->
                            (cr == {cr_count{cr_reset_value}}) && (flags == '0) && !cr_action)
    else report_mismatch("outputs not at reset values during reset");
  a_cr: assert property (@(posedge hclk) disable iff (!hresetn) cr == m_cr)
    else report_mismatch($sformatf("cr %h, expected %h", $sampled(cr), $sampled(m_cr)));
  a_flags: assert property (@(posedge hclk) disable iff (!hresetn) flags == m_flags)
    else report_mismatch($sformatf("flags %h, expected %h", $sampled(flags),
                                   $sampled(m_flags)));
  a_action: assert property (@(posedge hclk) disable iff (!hresetn) cr_action == m_action)
    else report_mismatch($sformatf("cr_action %b, expected %b", $sampled(cr_action),
                                   $sampled(m_action)));
  a_rdata: assert property (@(posedge hclk) disable iff (!hresetn) m_rd |-> hrdata == exp_rdata)
    else report_mismatch($sformatf("hrdata %h at %h, expected %h", $sampled(hrdata),
                                   $sampled(m_addr), $sampled(exp_rdata)));
  a_resp: assert property (@(posedge hclk) disable iff (!hresetn) hreadyout && (hresp == 1'b0))
    else report_mismatch("slave stalled or answered ERROR");

  // cycle counter guards against a hung run
  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge hclk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
    stop_run_failed();
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial
  begin
    int        slot;
    sfr_word_t bits;
    hresetn    = 1'b1;      // dropped below so the async reset sees a real edge
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = 2'b00;
    hwrite     = 1'b0;
    hready     = 1'b1;
    hwdata     = '0;
    sfr_lock   = 1'b0;
    status     = '0;
    flag_set   = '0;
    set_next   = '0;
    lock_level = 1'b0;
    wdata_next = '0;
    #1 hresetn = 1'b0;
    repeat (3) @(posedge hclk);
    hresetn <= 1'b1;
    bus_idle();
    for (int i = 0; i <= cr_count; i++)
      read_word(12'(4 * i));                 // reset values, slot 4 unmapped
    for (int i = 0; i < 40; i++)
    begin
      slot = {$random(seed)} % cr_count;
      write_then_read(12'(4 * slot), 32'($random(seed)));
    end
    for (int i = 0; i < 10; i++)
      read_word(sr_addr);                    // live status
    write_then_read(sr_addr, 32'($random(seed)));
    write_word(12'h010, 32'hdead_beef);      // past the last control slot
    for (int i = 0; i < cr_count; i++)
      read_word(12'(4 * i));
    read_word(12'h01c);
    read_word(12'h02c);
    read_word(12'h100);
    read_word(12'hffc);
    read_word(12'h022);
    read_word(12'h026);
    busy_beat(12'h004, 32'h0000_1234);
    read_word(12'h004);
    // sticky flags
    for (int i = 0; i < 20; i++)
      pulse_flags(16'($random(seed)) & 16'($random(seed)));
    for (int i = 0; i < 10; i++)
    begin
      write_then_read(fr_addr, 32'($random(seed)));
      pulse_flags(16'($random(seed)));
    end
    for (int i = 0; i < 5; i++)
    begin
      bits = 16'($random(seed));
      clear_flags_during_set(16'hffff, bits);
      read_word(fr_addr);
    end
    // action pulse
    write_word(ar_addr, {16'h0, ar_key});
    repeat (2) bus_idle();
    write_word(ar_addr, 32'h0000_0031);
    write_word(ar_addr, 32'($random(seed)));
    address_phase(ar_addr, 1'b1, {16'h0, ar_key}, 2'b10);
    address_phase(ar_addr, 1'b0, '0, 2'b11); // reads as 0 during the pulse setup
    bus_idle();
    // lock blocks writes, reads continue
    lock_level = 1'b1;
    pulse_flags(16'h0f0f);
    write_then_read(12'h000, 32'h0000_a5a5);
    write_then_read(fr_addr, 32'h0000_ffff);
    write_word(ar_addr, {16'h0, ar_key});
    read_word(12'h008);
    read_word(sr_addr);
    lock_level = 1'b0;
    write_then_read(fr_addr, 32'h0000_ffff);
    repeat (4) bus_idle();
    @(negedge hclk);                         // checks of the last edge have run
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* ahb_sfr.f */
+incdir+tb
src/ahb_pkg.sv
src/sfr_pkg.sv
src/sfr_access_if.sv
src/ahb_addr_phase.sv
src/sfr_ctrl_regs.sv
src/sfr_flag_regs.sv
src/ahb_sfr_top.sv
tb/ahb_sfr_tb.sv

/* Bender.yml */
package:
  name: ahb_sfr

sources:
  # packages first, then the interface and the stages, top last
  - src/ahb_pkg.sv
  - src/sfr_pkg.sv
  - src/sfr_access_if.sv
  - src/ahb_addr_phase.sv
  - src/sfr_ctrl_regs.sv
  - src/sfr_flag_regs.sv
  - src/ahb_sfr_top.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/ahb_sfr_tb.sv
